// ==== design/mips_pkg.sv ====
////////////////////////////////////////
// mips core shared definitions
// widths, opcodes, alu codes and the instruction word view
////////////////////////////////////////
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // one instruction word, read as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SUB = 4'b0110;
    localparam logic [3:0] ALU_SLT = 4'b0111;

    localparam word_t PC_RESET   = 32'h0040_0000;
    localparam int    IMEM_WORDS = 256;     // word offset from PC_RESET
    localparam int    DMEM_WORDS = 256;     // address bits 9:2

    localparam logic [1:0] STALL_ALU  = 2'd1;   // bubbles behind alu or addi
    localparam logic [1:0] STALL_LOAD = 2'd2;   // bubbles behind lw

endpackage

// ==== design/fetch_unit.sv ====
////////////////////////////////////////
// fetch unit
// program counter and instruction rom
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_unit (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic              stall,
    input  logic              branch_taken,
    input  mips_pkg::word_t   branch_target,
    output mips_pkg::word_t   pc,
    output mips_pkg::word_t   instr
);
    mips_pkg::word_t rom [mips_pkg::IMEM_WORDS];
    mips_pkg::word_t pc_offset;

    initial
    begin
        for (int i = 0; i < mips_pkg::IMEM_WORDS; i++)
            rom[i] = '0;                        // unused words read as nop
        $readmemh("program.hex", rom);
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= mips_pkg::PC_RESET;
        else if (stall)
            pc <= pc;                           // hold behind a hazard
        else if (branch_taken)
            pc <= branch_target;
        else
            pc <= pc + 32'd4;
    end

    assign pc_offset = pc - mips_pkg::PC_RESET;
    assign instr     = rom[pc_offset[$clog2(mips_pkg::IMEM_WORDS)+1:2]];

    // branch targets come from decode and must keep the pc on a word
    a_pc_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        pc[1:0] == 2'b00);

endmodule

// ==== design/decode_stage.sv ====
////////////////////////////////////////
// decode stage
// if/id register, control decode, operand forward, branch resolve
////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  stall,
    input  mips_pkg::word_t       f_instr,
    input  mips_pkg::word_t       f_pc,
    input  logic                  fwd_rs,
    input  logic                  fwd_rt,
    input  mips_pkg::word_t       mem_alu_result,
    input  mips_pkg::word_t       rf_rs_data,
    input  mips_pkg::word_t       rf_rt_data,
    output mips_pkg::instr_u      d_instr,
    output logic                  branch_taken,
    output mips_pkg::word_t       branch_target,
    output mips_pkg::word_t       rs_val,
    output mips_pkg::word_t       rt_val,
    output mips_pkg::word_t       imm_ext,
    output mips_pkg::reg_addr_t   dest_reg,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  alu_src_imm,
    output logic                  alu_is_rtype
);
    mips_pkg::word_t d_pc;
    logic [5:0]      opcode;
    logic            is_beq;
    logic            is_bne;
    logic            operands_eq;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            d_instr <= '0;
        else if (!stall)
            d_instr <= branch_taken ? '0 : f_instr;    // kill the slot behind a taken branch
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            d_pc <= f_pc;
    end

    assign opcode = d_instr.r.opcode;

    // the all-zero nop has the R opcode but must not write
    assign alu_is_rtype = (opcode == mips_pkg::OP_RTYPE) && (d_instr != '0);
    assign reg_write    = alu_is_rtype || (opcode == mips_pkg::OP_ADDI) ||
                          (opcode == mips_pkg::OP_LW);
    assign mem_read     = (opcode == mips_pkg::OP_LW);
    assign mem_write    = (opcode == mips_pkg::OP_SW);
    assign mem_to_reg   = (opcode == mips_pkg::OP_LW);
    assign alu_src_imm  = (opcode == mips_pkg::OP_ADDI) || (opcode == mips_pkg::OP_LW) ||
                          (opcode == mips_pkg::OP_SW);
    assign is_beq       = (opcode == mips_pkg::OP_BEQ);
    assign is_bne       = (opcode == mips_pkg::OP_BNE);

    assign dest_reg = alu_is_rtype ? d_instr.r.rd : d_instr.i.rt;    // rd for R, rt for I
    assign imm_ext  = {{16{d_instr.i.imm[15]}}, d_instr.i.imm};

    assign rs_val = fwd_rs ? mem_alu_result : rf_rs_data;
    assign rt_val = fwd_rt ? mem_alu_result : rf_rt_data;

    assign operands_eq   = (rs_val == rt_val);
    assign branch_target = d_pc + 32'd4 + (imm_ext << 2);

    // operands are stale while stalled, so no branch decision then
    assign branch_taken = !stall && ((is_beq && operands_eq) || (is_bne && !operands_eq));

endmodule

// ==== design/register_file.sv ====
////////////////////////////////////////
// register file
// 32 words, two read ports, write-first bypass
////////////////////////////////////////
`timescale 1ns/1ps

module register_file (
    input  logic                  SYS_clk,
    input  mips_pkg::reg_addr_t   rs_addr,
    input  mips_pkg::reg_addr_t   rt_addr,
    output mips_pkg::word_t       rs_data,
    output mips_pkg::word_t       rt_data,
    input  logic                  we,
    input  mips_pkg::reg_addr_t   wr_addr,
    input  mips_pkg::word_t       wr_data
);
    mips_pkg::word_t regs [32];

    always_ff @(posedge SYS_clk)
    begin
        if (we && (wr_addr != '0))
            regs[wr_addr] <= wr_data;
    end

    // same cycle write is seen by decode
    assign rs_data = (rs_addr == '0)                ? '0      :
                     (we && (wr_addr == rs_addr))   ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0)                ? '0      :
                     (we && (wr_addr == rt_addr))   ? wr_data : regs[rt_addr];

    // writeback already drops writes to register 0
    a_no_r0_write: assert property (@(posedge SYS_clk) we |-> (wr_addr != '0));

endmodule

// ==== design/hazard_unit.sv ====
////////////////////////////////////////
// hazard unit
// stall counter and mem to decode forward selects
////////////////////////////////////////
`timescale 1ns/1ps

module hazard_unit (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  mips_pkg::instr_u   d_instr,
    input  mips_pkg::instr_u   ex_instr,
    input  mips_pkg::instr_u   mem_instr,
    output logic               stall,
    output logic               fwd_rs,
    output logic               fwd_rt
);
    logic [1:0]          stall_cnt;     // bubbles still owed after this cycle
    logic [1:0]          cnt_now;
    logic                uses_rs;
    logic                uses_rt;
    mips_pkg::reg_addr_t ex_dst;
    mips_pkg::reg_addr_t mem_dst;
    logic                ex_hit;
    logic                mem_hit;
    logic                ex_alu;
    logic                ex_load;
    logic                mem_alu;
    logic                mem_load;

    function automatic mips_pkg::reg_addr_t dest_of(input mips_pkg::instr_u w);
        dest_of = (w.r.opcode == mips_pkg::OP_RTYPE) ? w.r.rd : w.i.rt;
    endfunction

    function automatic logic reads(input mips_pkg::reg_addr_t dst,
                                   input mips_pkg::instr_u d,
                                   input logic rs_used,
                                   input logic rt_used);
        reads = (dst != '0) && ((rs_used && dst == d.r.rs) || (rt_used && dst == d.r.rt));
    endfunction

    always_comb
    begin
        // store data comes from rt, so sw joins the two-source group
        uses_rs = (d_instr != '0);
        uses_rt = uses_rs && ((d_instr.r.opcode == mips_pkg::OP_RTYPE) ||
                              (d_instr.r.opcode == mips_pkg::OP_BEQ)   ||
                              (d_instr.r.opcode == mips_pkg::OP_BNE)   ||
                              (d_instr.r.opcode == mips_pkg::OP_SW));

        ex_alu   = (ex_instr.r.opcode == mips_pkg::OP_RTYPE) ||
                   (ex_instr.r.opcode == mips_pkg::OP_ADDI);
        ex_load  = (ex_instr.r.opcode == mips_pkg::OP_LW);
        mem_alu  = (mem_instr.r.opcode == mips_pkg::OP_RTYPE) ||
                   (mem_instr.r.opcode == mips_pkg::OP_ADDI);
        mem_load = (mem_instr.r.opcode == mips_pkg::OP_LW);

        ex_dst  = dest_of(ex_instr);     // nop gives rd 0 and never hits
        mem_dst = dest_of(mem_instr);
        ex_hit  = reads(ex_dst, d_instr, uses_rs, uses_rt);
        mem_hit = reads(mem_dst, d_instr, uses_rs, uses_rt);

        if (stall_cnt != 2'd0)
            cnt_now = stall_cnt;
        else if (ex_load && ex_hit)
            cnt_now = mips_pkg::STALL_LOAD;
        else if ((ex_alu && ex_hit) || (mem_load && mem_hit))
            cnt_now = mips_pkg::STALL_ALU;      // load data reaches decode through the bypass
        else
            cnt_now = 2'd0;
    end

    assign stall = (cnt_now != 2'd0);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            stall_cnt <= 2'd0;
        else if (stall)
            stall_cnt <= cnt_now - 2'd1;
        else
            stall_cnt <= 2'd0;
    end

    assign fwd_rs = mem_alu && (mem_dst != '0) && (mem_dst == d_instr.r.rs);
    assign fwd_rt = mem_alu && (mem_dst != '0) && (mem_dst == d_instr.r.rt);

    a_cnt_bound: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall_cnt <= mips_pkg::STALL_LOAD);

    // a pending count means execute already holds the bubble from last cycle
    a_cnt_bubble: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (stall_cnt != 2'd0) |-> (ex_instr == '0));

endmodule

// ==== design/execute_stage.sv ====
////////////////////////////////////////
// execute stage
// id/ex register, alu control and alu
////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  bubble,
    input  mips_pkg::instr_u      d_instr,
    input  mips_pkg::word_t       rs_val,
    input  mips_pkg::word_t       rt_val,
    input  mips_pkg::word_t       imm_ext,
    input  mips_pkg::reg_addr_t   dest_reg,
    input  logic                  reg_write,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  mem_to_reg,
    input  logic                  alu_src_imm,
    input  logic                  alu_is_rtype,
    output mips_pkg::instr_u      ex_instr,
    output mips_pkg::word_t       alu_result,
    output mips_pkg::word_t       store_data,
    output mips_pkg::reg_addr_t   ex_dest,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write,
    output logic                  ex_mem_to_reg
);
    mips_pkg::word_t ex_a;
    mips_pkg::word_t ex_b;
    mips_pkg::word_t ex_imm;
    mips_pkg::word_t alu_in_b;
    logic            ex_src_imm;
    logic            ex_is_rtype;
    logic [3:0]      alu_ctrl;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || bubble)
        begin
            ex_instr      <= '0;                // nop into execute
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_src_imm    <= 1'b0;
            ex_is_rtype   <= 1'b0;
        end
        else
        begin
            ex_instr      <= d_instr;
            ex_reg_write  <= reg_write;
            ex_mem_read   <= mem_read;
            ex_mem_write  <= mem_write;
            ex_mem_to_reg <= mem_to_reg;
            ex_src_imm    <= alu_src_imm;
            ex_is_rtype   <= alu_is_rtype;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_a    <= rs_val;
        ex_b    <= rt_val;
        ex_imm  <= imm_ext;
        ex_dest <= dest_reg;
    end

    always_comb
    begin
        alu_ctrl = mips_pkg::ALU_ADD;           // addi, lw, sw address
        if (ex_is_rtype)
        begin
            case (ex_instr.r.funct)
                mips_pkg::FN_ADD: alu_ctrl = mips_pkg::ALU_ADD;
                mips_pkg::FN_SUB: alu_ctrl = mips_pkg::ALU_SUB;
                mips_pkg::FN_AND: alu_ctrl = mips_pkg::ALU_AND;
                mips_pkg::FN_OR:  alu_ctrl = mips_pkg::ALU_OR;
                mips_pkg::FN_SLT: alu_ctrl = mips_pkg::ALU_SLT;
                default:          alu_ctrl = mips_pkg::ALU_ADD;
            endcase
        end
    end

    assign alu_in_b = ex_src_imm ? ex_imm : ex_b;

    always_comb
    begin
        case (alu_ctrl)
            mips_pkg::ALU_SUB: alu_result = ex_a - alu_in_b;
            mips_pkg::ALU_AND: alu_result = ex_a & alu_in_b;
            mips_pkg::ALU_OR:  alu_result = ex_a | alu_in_b;
            mips_pkg::ALU_SLT: alu_result = {31'd0, $signed(ex_a) < $signed(alu_in_b)};
            default:           alu_result = ex_a + alu_in_b;
        endcase
    end

    assign store_data = ex_b;

endmodule

// ==== design/memory_stage.sv ====
////////////////////////////////////////
// memory stage
// ex/mem register and data ram
////////////////////////////////////////
`timescale 1ns/1ps

module memory_stage (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  mips_pkg::instr_u      ex_instr,
    input  mips_pkg::word_t       alu_result,
    input  mips_pkg::word_t       store_data,
    input  mips_pkg::reg_addr_t   ex_dest,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    input  logic                  ex_mem_to_reg,
    output mips_pkg::instr_u      mem_instr,
    output mips_pkg::word_t       mem_alu_result,
    output mips_pkg::word_t       load_data,
    output mips_pkg::reg_addr_t   mem_dest,
    output logic                  reg_write,
    output logic                  mem_to_reg
);
    mips_pkg::word_t dmem [mips_pkg::DMEM_WORDS];
    mips_pkg::word_t mem_wdata;
    logic            mem_read_q;
    logic            mem_write_q;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_instr   <= '0;
            reg_write   <= 1'b0;
            mem_to_reg  <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end
        else
        begin
            mem_instr   <= ex_instr;
            reg_write   <= ex_reg_write;
            mem_to_reg  <= ex_mem_to_reg;
            mem_read_q  <= ex_mem_read;
            mem_write_q <= ex_mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= alu_result;
        mem_wdata      <= store_data;
        mem_dest       <= ex_dest;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (mem_write_q)
            dmem[mem_alu_result[9:2]] <= mem_wdata;    // word address
    end

    assign load_data = mem_read_q ? dmem[mem_alu_result[9:2]] : '0;

endmodule

// ==== design/writeback_stage.sv ====
////////////////////////////////////////
// writeback stage
// mem/wb register and result select
////////////////////////////////////////
`timescale 1ns/1ps

module writeback_stage (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  mips_pkg::word_t       mem_alu_result,
    input  mips_pkg::word_t       load_data,
    input  mips_pkg::reg_addr_t   mem_dest,
    input  logic                  reg_write,
    input  logic                  mem_to_reg,
    output logic                  wb_valid,
    output mips_pkg::reg_addr_t   wb_reg,
    output mips_pkg::word_t       wb_data
);
    mips_pkg::word_t wb_alu;
    mips_pkg::word_t wb_load;
    logic            wb_sel_load;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_valid    <= 1'b0;
            wb_sel_load <= 1'b0;
        end
        else
        begin
            wb_valid    <= reg_write && (mem_dest != '0);  // r0 writes dropped here
            wb_sel_load <= mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_reg  <= mem_dest;
        wb_alu  <= mem_alu_result;
        wb_load <= load_data;
    end

    assign wb_data = wb_sel_load ? wb_load : wb_alu;

endmodule

// ==== design/mips_core.sv ====
////////////////////////////////////////
// mips core top
// five stage pipeline, register writes visible on the wb port
////////////////////////////////////////
`timescale 1ns/1ps

module mips_core (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    output logic                  wb_valid,
    output mips_pkg::reg_addr_t   wb_reg,
    output mips_pkg::word_t       wb_data
);
    mips_pkg::word_t     f_pc;
    mips_pkg::word_t     f_instr;
    logic                stall;
    logic                branch_taken;
    mips_pkg::word_t     branch_target;

    mips_pkg::instr_u    d_instr;
    mips_pkg::word_t     rf_rs_data;
    mips_pkg::word_t     rf_rt_data;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    mips_pkg::word_t     imm_ext;
    mips_pkg::reg_addr_t dest_reg;
    logic                fwd_rs;
    logic                fwd_rt;
    logic                d_reg_write;
    logic                d_mem_read;
    logic                d_mem_write;
    logic                d_mem_to_reg;
    logic                d_alu_src_imm;
    logic                d_alu_is_rtype;

    mips_pkg::instr_u    ex_instr;
    mips_pkg::word_t     alu_result;
    mips_pkg::word_t     store_data;
    mips_pkg::reg_addr_t ex_dest;
    logic                ex_reg_write;
    logic                ex_mem_read;
    logic                ex_mem_write;
    logic                ex_mem_to_reg;

    mips_pkg::instr_u    mem_instr;
    mips_pkg::word_t     mem_alu_result;
    mips_pkg::word_t     load_data;
    mips_pkg::reg_addr_t mem_dest;
    logic                mem_reg_write;
    logic                mem_to_reg;

    fetch_unit u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (f_pc),
        .instr         (f_instr)
    );

    decode_stage u_decode (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .stall          (stall),
        .f_instr        (f_instr),
        .f_pc           (f_pc),
        .fwd_rs         (fwd_rs),
        .fwd_rt         (fwd_rt),
        .mem_alu_result (mem_alu_result),
        .rf_rs_data     (rf_rs_data),
        .rf_rt_data     (rf_rt_data),
        .d_instr        (d_instr),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .rs_val         (rs_val),
        .rt_val         (rt_val),
        .imm_ext        (imm_ext),
        .dest_reg       (dest_reg),
        .reg_write      (d_reg_write),
        .mem_read       (d_mem_read),
        .mem_write      (d_mem_write),
        .mem_to_reg     (d_mem_to_reg),
        .alu_src_imm    (d_alu_src_imm),
        .alu_is_rtype   (d_alu_is_rtype)
    );

    register_file u_regs (
        .SYS_clk (SYS_clk),
        .rs_addr (d_instr.r.rs),
        .rt_addr (d_instr.r.rt),
        .rs_data (rf_rs_data),
        .rt_data (rf_rt_data),
        .we      (wb_valid),
        .wr_addr (wb_reg),
        .wr_data (wb_data)
    );

    hazard_unit u_hazard (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .d_instr   (d_instr),
        .ex_instr  (ex_instr),
        .mem_instr (mem_instr),
        .stall     (stall),
        .fwd_rs    (fwd_rs),
        .fwd_rt    (fwd_rt)
    );

    execute_stage u_execute (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .bubble        (stall),
        .d_instr       (d_instr),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .imm_ext       (imm_ext),
        .dest_reg      (dest_reg),
        .reg_write     (d_reg_write),
        .mem_read      (d_mem_read),
        .mem_write     (d_mem_write),
        .mem_to_reg    (d_mem_to_reg),
        .alu_src_imm   (d_alu_src_imm),
        .alu_is_rtype  (d_alu_is_rtype),
        .ex_instr      (ex_instr),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_mem_to_reg (ex_mem_to_reg)
    );

    memory_stage u_memory (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .ex_instr       (ex_instr),
        .alu_result     (alu_result),
        .store_data     (store_data),
        .ex_dest        (ex_dest),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_mem_to_reg  (ex_mem_to_reg),
        .mem_instr      (mem_instr),
        .mem_alu_result (mem_alu_result),
        .load_data      (load_data),
        .mem_dest       (mem_dest),
        .reg_write      (mem_reg_write),
        .mem_to_reg     (mem_to_reg)
    );

    writeback_stage u_writeback (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .mem_alu_result (mem_alu_result),
        .load_data      (load_data),
        .mem_dest       (mem_dest),
        .reg_write      (mem_reg_write),
        .mem_to_reg     (mem_to_reg),
        .wb_valid       (wb_valid),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data)
    );

endmodule

// ==== sim/tb_clock.sv ====
////////////////////////////////////////
// testbench clock
// free running 8 ns clock
////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 4;     // ns

    initial
    begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== sim/tb_mips_core.sv ====
////////////////////////////////////////
// mips core testbench
// isa reference model checks every write-back
////////////////////////////////////////
`timescale 1ns/1ps

module tb_mips_core;

    localparam string       PROG_FILE      = "sim/program.hex";
    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_MARGIN = 50;    // cycles on top of 3 per instruction
    localparam int          DRAIN_CYCLES   = 8;     // catch stray writes behind the last one
    localparam int          MAX_STEPS      = 10000;
    localparam logic [31:0] HALT_WORD      = 32'h1000_ffff;    // beq $0,$0,-1

    logic                SYS_clk;
    logic                SYS_reset;
    logic                wb_valid;
    mips_pkg::reg_addr_t wb_reg;
    mips_pkg::word_t     wb_data;

    logic [31:0] prog [mips_pkg::IMEM_WORDS];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_data [$];
    int          exp_total     = 0;
    int          checked_count = 0;
    int          exec_count    = 0;
    int          watch_cycles  = 0;
    logic        ref_ready     = 1'b0;

    tb_clock u_clock (
        .clk (SYS_clk)
    );

    mips_core UUT (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    // runs the program in order, returns instructions executed or -1
    function automatic int run_reference();
        logic [31:0] regs [32];
        logic [31:0] dmem [mips_pkg::DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  dst;
        logic        wr;
        int          idx;

        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        pc = mips_pkg::PC_RESET;
        for (int n = 0; n < MAX_STEPS; n++)
        begin
            idx = int'((pc - mips_pkg::PC_RESET) >> 2);
            if ((pc[1:0] != 2'b00) || (idx < 0) || (idx >= mips_pkg::IMEM_WORDS))
                return -1;
            ins = prog[idx];
            if (ins == HALT_WORD)
                return n;
            op   = ins[31:26];
            fn   = ins[5:0];
            imm  = {{16{ins[15]}}, ins[15:0]};
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            addr = a + imm;
            wr   = 1'b0;
            dst  = '0;
            res  = '0;
            pc   = pc + 32'd4;
            case (op)
                mips_pkg::OP_RTYPE:
                begin
                    dst = ins[15:11];
                    wr  = 1'b1;
                    case (fn)
                        mips_pkg::FN_ADD: res = a + b;
                        mips_pkg::FN_SUB: res = a - b;
                        mips_pkg::FN_AND: res = a & b;
                        mips_pkg::FN_OR:  res = a | b;
                        mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr  = 1'b0;      // nop and unused functs
                    endcase
                end
                mips_pkg::OP_ADDI:
                begin
                    dst = ins[20:16];
                    wr  = 1'b1;
                    res = addr;
                end
                mips_pkg::OP_LW:
                begin
                    dst = ins[20:16];
                    wr  = 1'b1;
                    res = dmem[addr[9:2]];
                end
                mips_pkg::OP_SW:  dmem[addr[9:2]] = b;
                mips_pkg::OP_BEQ: if (a == b) pc = pc + (imm << 2);
                mips_pkg::OP_BNE: if (a != b) pc = pc + (imm << 2);
                default:          return -1;
            endcase
            if (wr && (dst != 5'd0))
            begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_data.push_back(res);
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s = 0x%08h, expected 0x%08h (write %0d)",
                     name, actual, expected, checked_count);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    initial
    begin
        SYS_reset <= 1'b1;
        for (int i = 0; i < mips_pkg::IMEM_WORDS; i++)
            prog[i] = '0;
        $readmemh(PROG_FILE, prog);
        exec_count = run_reference();
        if (exec_count < 0)
        begin
            $display("reference model did not reach the halt word");
            $display("tests failed");
            $fatal(1, "bad program");
        end
        else
        begin
            exp_total    = exp_reg.size();
            watch_cycles = 3 * exec_count + TIMEOUT_MARGIN;
            repeat (RESET_CYCLES) @(posedge SYS_clk);
            SYS_reset <= 1'b0;
            ref_ready = 1'b1;
            wait (checked_count == exp_total);
            repeat (DRAIN_CYCLES) @(posedge SYS_clk);
            if ((checked_count == exp_total) && (exp_total > 0))
            begin
                $display("all tests passed");
                $finish;
            end
            else
            begin
                $display("tests failed");
                $fatal(1, "write count wrong");
            end
        end
    end

    // wb outputs are registered, stable at the falling edge
    always @(negedge SYS_clk)
    begin : compare_writes
        logic [4:0]  want_reg;
        logic [31:0] want_data;

        if (!SYS_reset && (wb_valid === 1'b1))
        begin
            if (checked_count >= exp_total)
            begin
                $display("unexpected register write to r%0d after the last expected one",
                         wb_reg);
                $display("tests failed");
                $fatal(1, "extra write");
            end
            else
            begin
                want_reg  = exp_reg.pop_front();
                want_data = exp_data.pop_front();
                check_value("wb_reg", {27'd0, wb_reg}, {27'd0, want_reg});
                check_value("wb_data", wb_data, want_data);
                checked_count = checked_count + 1;
            end
        end
    end

    initial
    begin : watchdog
        wait (ref_ready);
        repeat (watch_cycles) @(posedge SYS_clk);
        $display("watchdog expired, only %0d of %0d register writes arrived",
                 checked_count, exp_total);
        $display("tests failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== sim/program.hex ====
// one 32-bit instruction word per line, hex, first word at 0x00400000
// a comment after a word gives its assembly
20010005 // addi $1,$0,5
2002fffd // addi $2,$0,-3
00221820 // add  $3,$1,$2
00222022 // sub  $4,$1,$2
00642824 // and  $5,$3,$4
00223025 // or   $6,$1,$2
0041382a // slt  $7,$2,$1
0022402a // slt  $8,$1,$2
21090040 // addi $9,$8,0x40
ad260004 // sw   $6,4($9)
8d2a0004 // lw   $10,4($9)
01475820 // add  $11,$10,$7
20200007 // addi $0,$1,7
00016020 // add  $12,$0,$1
200d0003 // addi $13,$0,3
01816020 // loop: add $12,$12,$1
21adffff // addi $13,$13,-1
15a0fffd // bne  $13,$0,loop
11a00001 // beq  $13,$0,+1
200f0063 // addi $15,$0,99 (skipped)
14210001 // bne  $1,$1,+1
10220001 // beq  $1,$2,+1
200f0077 // addi $15,$0,0x77
1000ffff // halt: beq $0,$0,-1

// ==== verilog.f ====
design/mips_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/register_file.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_stage.sv
design/writeback_stage.sv
design/mips_core.sv
sim/tb_clock.sv
sim/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the mips core testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"

# the instruction rom loads program.hex from the run directory
cp sim/program.hex program.hex

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mips_core -f verilog.f

./obj_dir/Vtb_mips_core | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
